// ==== source/renamePkg.sv ====
////////////////////
// Sizes, vector types and packets of the four-slot rename stage.
// The slot count is fixed at four by the lane structure of the design.
////////////////////

package renamePkg;

  localparam int numSlots      = 4;
  localparam int numLogical    = 32;
  localparam int numPhysical   = 64;
  localparam int freeListDepth = 32;   // Physical registers not mapped after reset.

  typedef logic [$clog2(numLogical)-1:0]    logReg_t;
  typedef logic [$clog2(numPhysical)-1:0]   phyReg_t;
  typedef logic [$clog2(freeListDepth)-1:0] freePtr_t;
  typedef logic [$clog2(freeListDepth):0]   freeCount_t;   // Holds 0 up to a full list.
  typedef logic [31:0]                      pc_t;
  typedef logic [7:0]                       opcode_t;
  typedef logic [15:0]                      imm_t;
  typedef logic [1:0]                       fuType_t;
  typedef logic [2:0]                       width_t;
  typedef logic [numSlots-1:0]              slotMask_t;

  typedef struct packed {
    pc_t     pc;
    opcode_t opcode;
    imm_t    imm;
    fuType_t fuType;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
    logReg_t src1Log;
    logic    src1Valid;
    logReg_t src2Log;
    logic    src2Valid;
    logReg_t destLog;
    logic    destValid;
  } decodedPkt_t;

  typedef struct packed {
    phyReg_t src1Phys;
    phyReg_t src2Phys;
    phyReg_t oldPhys;   // Mapping that the destination replaces.
  } laneMap_t;

  typedef struct packed {
    pc_t     pc;
    opcode_t opcode;
    imm_t    imm;
    fuType_t fuType;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
    logReg_t src1Log;
    logic    src1Valid;
    logReg_t src2Log;
    logic    src2Valid;
    logReg_t destLog;
    logic    destValid;
    phyReg_t src1Phys;
    phyReg_t src2Phys;
    phyReg_t destPhys;
    phyReg_t oldPhys;
    logic    valid;
  } renamedPkt_t;

  typedef struct packed {
    logic    valid;
    phyReg_t physReg;
  } commitPort_t;

  typedef struct packed {
    logReg_t destLog;
    phyReg_t physMap;
  } recoverPort_t;

endpackage

// ==== source/freeList.sv ====
////////////////////
// Circular list of free physical registers; grants are valid only while four are free.
// Commits are trusted never to return more registers than the list can hold.
////////////////////

`timescale 1ns/100ps

module freeList (
  input  logic                                                clk,
  input  logic                                                rstN_i,
  input  renamePkg::slotMask_t                                allocReq_i,
  input  renamePkg::commitPort_t [renamePkg::numSlots-1:0]    commit_i,
  output renamePkg::phyReg_t [renamePkg::numSlots-1:0]        freeReg_o,
  output logic                                                freeListEmpty_o
);

  renamePkg::phyReg_t     freeMem [renamePkg::freeListDepth];
  renamePkg::freePtr_t    head;
  renamePkg::freePtr_t    tail;
  renamePkg::freeCount_t  count;
  renamePkg::freeCount_t  allocCount;
  renamePkg::freeCount_t  commitCount;
  renamePkg::freePtr_t    pushIdx [renamePkg::numSlots];

  // Each requesting slot takes the entry after those of the requesting slots below it.
  always_comb begin : grantOrder
    renamePkg::freeCount_t seen;
    seen = '0;
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      freeReg_o[i] = freeMem[head + renamePkg::freePtr_t'(seen)];
      if (allocReq_i[i]) begin
        seen++;
      end
    end
    allocCount = seen;
  end

  always_comb begin : commitOrder
    renamePkg::freeCount_t seen;
    seen = '0;
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      pushIdx[i] = tail + renamePkg::freePtr_t'(seen);   // Valid ports pack at the tail.
      if (commit_i[i].valid) begin
        seen++;
      end
    end
    commitCount = seen;
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int k = 0; k < renamePkg::freeListDepth; k++) begin
        freeMem[k] <= renamePkg::phyReg_t'(renamePkg::numLogical + k);
      end
      head  <= '0;
      tail  <= '0;   // Full list, so the tail meets the head.
      count <= renamePkg::freeCount_t'(renamePkg::freeListDepth);
    end else begin
      for (int i = 0; i < renamePkg::numSlots; i++) begin
        if (commit_i[i].valid) begin
          freeMem[pushIdx[i]] <= commit_i[i].physReg;
        end
      end
      head  <= head + renamePkg::freePtr_t'(allocCount);
      tail  <= tail + renamePkg::freePtr_t'(commitCount);
      count <= count - allocCount + commitCount;
    end
  end

  // A whole group must be coverable, so the flag ignores the current requests.
  assign freeListEmpty_o = (count < renamePkg::freeCount_t'(renamePkg::numSlots));

endmodule

// ==== source/mapTable.sv ====
////////////////////
// Logical to physical map with in-group bypass; recovery writes take priority.
// Lookups bypass only for sources and destinations whose valid bit is set.
////////////////////

`timescale 1ns/100ps

module mapTable (
  input  logic                                                clk,
  input  logic                                                rstN_i,
  input  renamePkg::decodedPkt_t [renamePkg::numSlots-1:0]    decoded_i,
  input  renamePkg::slotMask_t                                allocReq_i,
  input  renamePkg::phyReg_t [renamePkg::numSlots-1:0]        destPhys_i,
  input  logic                                                recoverFlag_i,
  input  renamePkg::recoverPort_t [renamePkg::numSlots-1:0]   recover_i,
  output renamePkg::laneMap_t [renamePkg::numSlots-1:0]       laneMap_o
);

  renamePkg::phyReg_t mapMem [renamePkg::numLogical];

  // Scanning earlier slots upward leaves the nearest writer in place.
  always_comb begin
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      laneMap_o[i].src1Phys = mapMem[decoded_i[i].src1Log];
      laneMap_o[i].src2Phys = mapMem[decoded_i[i].src2Log];
      laneMap_o[i].oldPhys  = mapMem[decoded_i[i].destLog];
      for (int j = 0; j < i; j++) begin
        if (allocReq_i[j]) begin
          if (decoded_i[i].src1Valid && decoded_i[j].destLog == decoded_i[i].src1Log) begin
            laneMap_o[i].src1Phys = destPhys_i[j];
          end
          if (decoded_i[i].src2Valid && decoded_i[j].destLog == decoded_i[i].src2Log) begin
            laneMap_o[i].src2Phys = destPhys_i[j];
          end
          if (decoded_i[i].destValid && decoded_i[j].destLog == decoded_i[i].destLog) begin
            laneMap_o[i].oldPhys = destPhys_i[j];
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int k = 0; k < renamePkg::numLogical; k++) begin
        mapMem[k] <= renamePkg::phyReg_t'(k);   // Identity map out of reset.
      end
    end else if (recoverFlag_i) begin
      for (int p = 0; p < renamePkg::numSlots; p++) begin
        mapMem[recover_i[p].destLog] <= recover_i[p].physMap;   // Later port wins.
      end
    end else begin
      for (int i = 0; i < renamePkg::numSlots; i++) begin
        if (allocReq_i[i]) begin
          mapMem[decoded_i[i].destLog] <= destPhys_i[i];
        end
      end
    end
  end

endmodule

// ==== source/renameLane.sv ====
////////////////////
// One rename slot with a single output register stage.
////////////////////

`timescale 1ns/100ps

module renameLane (
  input  logic                    clk,
  input  logic                    rstN_i,
  input  logic                    enable_i,
  input  renamePkg::decodedPkt_t  decoded_i,
  input  renamePkg::laneMap_t     laneMap_i,
  input  renamePkg::phyReg_t      freeReg_i,
  output logic                    allocReq_o,
  output renamePkg::renamedPkt_t  renamed_o
);

  renamePkg::renamedPkt_t renamedNext;
  renamePkg::renamedPkt_t pktQ;
  logic                   validQ;

  assign allocReq_o = enable_i & decoded_i.destValid;

  always_comb begin
    renamedNext.pc        = decoded_i.pc;
    renamedNext.opcode    = decoded_i.opcode;
    renamedNext.imm       = decoded_i.imm;
    renamedNext.fuType    = decoded_i.fuType;
    renamedNext.isLoad    = decoded_i.isLoad;
    renamedNext.isStore   = decoded_i.isStore;
    renamedNext.isBranch  = decoded_i.isBranch;
    renamedNext.src1Log   = decoded_i.src1Log;
    renamedNext.src1Valid = decoded_i.src1Valid;
    renamedNext.src2Log   = decoded_i.src2Log;
    renamedNext.src2Valid = decoded_i.src2Valid;
    renamedNext.destLog   = decoded_i.destLog;
    renamedNext.destValid = decoded_i.destValid;
    renamedNext.src1Phys  = laneMap_i.src1Phys;
    renamedNext.src2Phys  = laneMap_i.src2Phys;
    renamedNext.destPhys  = freeReg_i;   // Granted register, meaningful only with destValid.
    renamedNext.oldPhys   = laneMap_i.oldPhys;
    renamedNext.valid     = enable_i;
  end

  always_ff @(posedge clk) begin
    pktQ <= renamedNext;
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      validQ <= 1'b0;
    end else begin
      validQ <= enable_i;
    end
  end

  always_comb begin
    renamed_o       = pktQ;
    renamed_o.valid = validQ;
  end

endmodule

// ==== source/rename.sv ====
////////////////////
// Four-slot rename stage; a group is taken whole or not at all, one cycle latency.
// Widths of 0 or above 4 enable no slot.
////////////////////

`timescale 1ns/100ps

module rename (
  input  logic                                                clk,
  input  logic                                                rstN_i,
  input  logic                                                stall_i,
  input  logic                                                decodeReady_i,
  input  renamePkg::width_t                                   frontEndWidth_i,
  input  renamePkg::decodedPkt_t [renamePkg::numSlots-1:0]    decodedPacket_i,
  input  renamePkg::commitPort_t [renamePkg::numSlots-1:0]    commit_i,
  input  logic                                                recoverFlag_i,
  input  renamePkg::recoverPort_t [renamePkg::numSlots-1:0]   recover_i,
  output renamePkg::renamedPkt_t [renamePkg::numSlots-1:0]    renamedPacket_o,
  output logic                                                freeListEmpty_o,
  output logic                                                renameReady_o
);

  renamePkg::slotMask_t                         slotMask;
  renamePkg::slotMask_t                         laneEnable;
  renamePkg::slotMask_t                         allocReq;
  renamePkg::phyReg_t [renamePkg::numSlots-1:0] freeReg;
  renamePkg::laneMap_t [renamePkg::numSlots-1:0] laneMap;
  logic                                         renameGo;

  always_comb begin
    case (frontEndWidth_i)
      3'd1:    slotMask = 4'b0001;
      3'd2:    slotMask = 4'b0011;
      3'd3:    slotMask = 4'b0111;
      3'd4:    slotMask = 4'b1111;
      default: slotMask = 4'b0000;
    endcase
  end

  // Recovery owns the map table write port, so renaming waits for it.
  assign renameGo      = decodeReady_i & ~stall_i & ~freeListEmpty_o & ~recoverFlag_i;
  assign laneEnable    = slotMask & {renamePkg::numSlots{renameGo}};
  assign renameReady_o = decodeReady_i & ~freeListEmpty_o;

  freeList freeListU (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .allocReq_i      (allocReq),
    .commit_i        (commit_i),
    .freeReg_o       (freeReg),
    .freeListEmpty_o (freeListEmpty_o)
  );

  mapTable mapTableU (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .decoded_i     (decodedPacket_i),
    .allocReq_i    (allocReq),
    .destPhys_i    (freeReg),
    .recoverFlag_i (recoverFlag_i),
    .recover_i     (recover_i),
    .laneMap_o     (laneMap)
  );

  for (genvar g = 0; g < renamePkg::numSlots; g++) begin : laneGen
    renameLane laneU (
      .clk        (clk),
      .rstN_i     (rstN_i),
      .enable_i   (laneEnable[g]),
      .decoded_i  (decodedPacket_i[g]),
      .laneMap_i  (laneMap[g]),
      .freeReg_i  (freeReg[g]),
      .allocReq_o (allocReq[g]),
      .renamed_o  (renamedPacket_o[g])
    );
  end

endmodule

// ==== testbench/rename_asserts.sv ====
////////////////////
// Port-level properties of the rename stage, bound into every rename instance.
////////////////////

`timescale 1ns/100ps

module renameAsserts (
  input logic                                             clk,
  input logic                                             rstN_i,
  input logic                                             stall_i,
  input renamePkg::renamedPkt_t [renamePkg::numSlots-1:0] renamedPacket_o
);

  function automatic logic anyValid(input renamePkg::renamedPkt_t [renamePkg::numSlots-1:0] p);
    logic v;
    v = 1'b0;
    for (int i = 0; i < renamePkg::numSlots; i++) v = v | p[i].valid;
    return v;
  endfunction

  function automatic logic destsDistinct(
      input renamePkg::renamedPkt_t [renamePkg::numSlots-1:0] p);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      for (int j = i + 1; j < renamePkg::numSlots; j++) begin
        if (p[i].valid && p[j].valid && p[i].destValid && p[j].destValid &&
            p[i].destPhys == p[j].destPhys) ok = 1'b0;
      end
    end
    return ok;
  endfunction

  quietInReset: assert property (@(posedge clk) !rstN_i |-> !anyValid(renamedPacket_o))
    else $error("Renamed output valid while reset is active.");

  quietAfterStall: assert property (@(posedge clk) disable iff (!rstN_i)
    stall_i |=> !anyValid(renamedPacket_o))
    else $error("Renamed output valid in the cycle after a stall.");

  uniqueDest: assert property (@(posedge clk) disable iff (!rstN_i)
    destsDistinct(renamedPacket_o))
    else $error("Two valid slots of one group got the same physical register.");

endmodule

// ==== testbench/renameTb.sv ====
////////////////////
// Random groups, commits and recoveries from a fixed LFSR seed, checked against a model.
// Commits return only replaced registers, and recoveries rotate existing mappings.
////////////////////

`timescale 1ns/100ps

module renameTb;

  localparam int numCycles = 400;
  localparam int timeoutNs = (numCycles + 10) * 10 + 500;

  logic                                               clk;
  logic                                               rstN;
  logic                                               stall;
  logic                                               decodeReady;
  renamePkg::width_t                                  frontEndWidth;
  renamePkg::decodedPkt_t [renamePkg::numSlots-1:0]   decodedPacket;
  renamePkg::commitPort_t [renamePkg::numSlots-1:0]   commit;
  logic                                               recoverFlag;
  renamePkg::recoverPort_t [renamePkg::numSlots-1:0]  recover;
  renamePkg::renamedPkt_t [renamePkg::numSlots-1:0]   renamedPacket;
  logic                                               freeListEmpty;
  logic                                               renameReady;

  logic [31:0]                                        lfsrState;
  int                                                 phase;   // 0 random, 1 drain, 2 refill.
  renamePkg::phyReg_t                                 mapModel [renamePkg::numLogical];
  renamePkg::phyReg_t                                 freeModel [$];
  renamePkg::phyReg_t                                 pendingOld [$];
  renamePkg::renamedPkt_t [renamePkg::numSlots-1:0]   expPrev;

  rename rename_i (
    .clk             (clk),
    .rstN_i          (rstN),
    .stall_i         (stall),
    .decodeReady_i   (decodeReady),
    .frontEndWidth_i (frontEndWidth),
    .decodedPacket_i (decodedPacket),
    .commit_i        (commit),
    .recoverFlag_i   (recoverFlag),
    .recover_i       (recover),
    .renamedPacket_o (renamedPacket),
    .freeListEmpty_o (freeListEmpty),
    .renameReady_o   (renameReady)
  );

  bind rename renameAsserts renameAssertsU (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(timeoutNs);
    $display("Run timed out before all test cycles were done.");
    $display("ERRORS FOUND");
    $fatal(1, "Timeout.");
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1; one step per bit taken.
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int b = 0; b < n; b++) begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      r         = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic stopOnError();
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at first mismatch.");
  endtask

  task automatic checkBit(input string name, input logic expV, input logic actV);
    if (actV !== expV) begin
      $display("Error at %0t: %s expected %b actual %b", $time, name, expV, actV);
      stopOnError();
    end
  endtask

  task automatic checkRenamed(input string name, input renamePkg::renamedPkt_t expV,
                              input renamePkg::renamedPkt_t actV);
    renamePkg::renamedPkt_t want;
    want = expV;
    if (!expV.valid) begin
      want       = actV;   // Only the valid bit matters in an empty slot.
      want.valid = 1'b0;
    end else if (!expV.destValid) begin
      want.destPhys = actV.destPhys;
    end
    if (actV !== want) begin
      $display("Error at %0t: %s expected %h actual %h", $time, name, want, actV);
      stopOnError();
    end
  endtask

  task automatic driveInputs();
    renamePkg::decodedPkt_t [renamePkg::numSlots-1:0]  pkts;
    renamePkg::commitPort_t [renamePkg::numSlots-1:0]  cms;
    renamePkg::recoverPort_t [renamePkg::numSlots-1:0] recs;
    renamePkg::logReg_t                                recA;
    renamePkg::logReg_t                                recB;
    renamePkg::logReg_t                                recC;
    logic                                              narrow;
    int                                                room;
    int                                                idx;
    narrow = randBits(1) != 0;   // Few logical registers, so bypasses happen often.
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      pkts[i].pc        = randBits(32);
      pkts[i].opcode    = renamePkg::opcode_t'(randBits(8));
      pkts[i].imm       = renamePkg::imm_t'(randBits(16));
      pkts[i].fuType    = renamePkg::fuType_t'(randBits(2));
      pkts[i].isLoad    = randBits(1) != 0;
      pkts[i].isStore   = randBits(1) != 0;
      pkts[i].isBranch  = randBits(1) != 0;
      pkts[i].src1Log   = renamePkg::logReg_t'(randBits(narrow ? 2 : 5));
      pkts[i].src1Valid = randBits(3) != 0;
      pkts[i].src2Log   = renamePkg::logReg_t'(randBits(narrow ? 2 : 5));
      pkts[i].src2Valid = randBits(3) != 0;
      pkts[i].destLog   = renamePkg::logReg_t'(randBits(narrow ? 2 : 5));
      pkts[i].destValid = (phase == 1) || (randBits(3) != 0);
    end
    recA = renamePkg::logReg_t'(randBits(5));
    recB = recA + renamePkg::logReg_t'(1 + randBits(4));   // Three distinct registers.
    recC = recB + renamePkg::logReg_t'(1 + randBits(3));
    recs[0] = {recB, mapModel[recA]};   // Port 2 overwrites this write.
    recs[1] = {recA, mapModel[recB]};
    recs[2] = {recB, mapModel[recC]};
    recs[3] = {recC, mapModel[recA]};   // The three mappings rotate, so none is held twice.
    room = renamePkg::freeListDepth - freeModel.size();
    for (int p = 0; p < renamePkg::numSlots; p++) begin
      cms[p] = '0;
      if (phase != 1 && pendingOld.size() > 0 && room > 0 &&
          randBits(phase == 0 ? 2 : 1) == 0) begin
        idx            = int'(randBits(6)) % pendingOld.size();
        cms[p].valid   = 1'b1;
        cms[p].physReg = pendingOld[idx];
        pendingOld.delete(idx);
        room--;
      end
    end
    decodedPacket <= pkts;
    commit        <= cms;
    recover       <= recs;
    if (phase == 0) begin
      stall         <= randBits(3) == 0;
      decodeReady   <= randBits(3) != 0;
      frontEndWidth <= renamePkg::width_t'(randBits(3));
      recoverFlag   <= randBits(4) == 0;
    end else begin
      stall         <= 1'b0;
      decodeReady   <= 1'b1;
      frontEndWidth <= renamePkg::width_t'(4);
      recoverFlag   <= 1'b0;
    end
  endtask

  // Checks last cycle's group, then predicts the group that the next edge captures.
  task automatic modelCycle();
    renamePkg::renamedPkt_t [renamePkg::numSlots-1:0] expNow;
    renamePkg::phyReg_t                               dps [renamePkg::numSlots];
    renamePkg::phyReg_t                               olds [renamePkg::numSlots];
    renamePkg::decodedPkt_t                           d;
    renamePkg::phyReg_t                               s1;
    renamePkg::phyReg_t                               s2;
    renamePkg::slotMask_t                             req;
    logic                                             empty;
    logic                                             go;
    logic                                             en;
    int                                               seen;
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      checkRenamed($sformatf("renamedPacket_o[%0d]", i), expPrev[i], renamedPacket[i]);
    end
    empty = freeModel.size() < renamePkg::numSlots;
    checkBit("freeListEmpty_o", empty, freeListEmpty);
    checkBit("renameReady_o", decodeReady && !empty, renameReady);
    go   = decodeReady && !stall && !empty && !recoverFlag;
    seen = 0;
    req  = '0;
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      d       = decodedPacket[i];
      s1      = mapModel[d.src1Log];
      s2      = mapModel[d.src2Log];
      olds[i] = mapModel[d.destLog];
      for (int j = 0; j < i; j++) begin
        if (req[j] && d.src1Valid && decodedPacket[j].destLog == d.src1Log) s1 = dps[j];
        if (req[j] && d.src2Valid && decodedPacket[j].destLog == d.src2Log) s2 = dps[j];
        if (req[j] && d.destValid && decodedPacket[j].destLog == d.destLog) olds[i] = dps[j];
      end
      en     = go && i < int'(frontEndWidth) && int'(frontEndWidth) <= renamePkg::numSlots;
      dps[i] = '0;
      if (en && d.destValid) begin
        dps[i] = freeModel[seen];
        req[i] = 1'b1;
        seen++;
      end
      expNow[i] = {d, s1, s2, dps[i], olds[i], en};
    end
    if (recoverFlag) begin
      for (int p = 0; p < renamePkg::numSlots; p++) begin
        mapModel[recover[p].destLog] = recover[p].physMap;
      end
    end
    for (int i = 0; i < renamePkg::numSlots; i++) begin
      if (req[i]) begin
        pendingOld.push_back(olds[i]);
        mapModel[decodedPacket[i].destLog] = dps[i];
      end
    end
    repeat (seen) void'(freeModel.pop_front());
    for (int p = 0; p < renamePkg::numSlots; p++) begin
      if (commit[p].valid) freeModel.push_back(commit[p].physReg);
    end
    expPrev = expNow;
  endtask

  initial begin
    lfsrState     = 32'hf483;
    phase         = 0;
    rstN          = 1'b0;
    stall         = 1'b0;
    decodeReady   = 1'b0;
    frontEndWidth = '0;
    decodedPacket = '0;
    commit        = '0;
    recoverFlag   = 1'b0;
    recover       = '0;
    expPrev       = '0;
    for (int k = 0; k < renamePkg::numLogical; k++) begin
      mapModel[k] = renamePkg::phyReg_t'(k);
    end
    for (int k = 0; k < renamePkg::freeListDepth; k++) begin
      freeModel.push_back(renamePkg::phyReg_t'(renamePkg::numLogical + k));
    end
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    for (int c = 0; c < numCycles; c++) begin
      phase = (c < 250) ? 0 : (c < 300) ? 1 : 2;
      @(posedge clk);
      driveInputs();
      @(negedge clk);
      modelCycle();
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== vlog.f ====
source/renamePkg.sv
source/freeList.sv
source/mapTable.sv
source/renameLane.sv
source/rename.sv
testbench/rename_asserts.sv
testbench/renameTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module renameTb -f vlog.f -o renameSim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/renameSim > sim.log 2>&1
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "Simulation passed" || { echo "No pass line in sim.log"; exit 1; }
